// ==== src/fpu_ncp_pkg.sv ====
`default_nettype none

package fpu_ncp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one single-precision value, or an integer result of a compare or classify.
    typedef logic [31:0] word_t;

    // accrued exception flags follow the usual RISC-V fcsr order.
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // codes not listed here decode like OP_MISC.
    typedef enum logic [3:0] {
        OP_CLASS = 4'h0,
        OP_CMP   = 4'h1,
        OP_MISC  = 4'h2
    } fpu_op_t;

    typedef logic [2:0] frm_t;

    typedef enum logic [3:0] {
        LE,
        LT,
        EQ,
        MIN,
        MAX,
        SGNJ,
        SGNJN,
        SGNJX,
        CLASS,
        MV
    } ncp_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lanes and constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a lower index wins arbitration.
    localparam int LANE_CMP  = 0;
    localparam int LANE_SGN  = 1;
    localparam int NUM_LANES = 2;

    localparam word_t CANONICAL_NAN = 32'h7fc0_0000;

endpackage

`default_nettype wire

// ==== src/fpu_lane_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// this carries the output handshake of one execution lane to the result arbiter.
interface fpu_lane_if #(
    parameter int NUM_THREADS = 4,
    parameter int TAGW        = 8
);

    logic                                   valid;
    logic                                   ready;
    logic [TAGW-1:0]                        tag;
    fpu_ncp_pkg::word_t [NUM_THREADS-1:0]   result;

    modport lane (
        output valid,
        output tag,
        output result,
        input  ready
    );

    modport arb (
        input  valid,
        input  tag,
        input  result,
        output ready
    );

endinterface

`default_nettype wire

// ==== src/fpu_ncp_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module fpu_ncp_decode (
    input  logic                  valid_in,
    input  fpu_ncp_pkg::fpu_op_t  op_type,
    input  fpu_ncp_pkg::frm_t     frm,
    input  logic                  cmp_ready,
    input  logic                  sgn_ready,
    output logic                  cmp_valid,
    output logic                  sgn_valid,
    output logic                  ready_in,
    output fpu_ncp_pkg::ncp_op_t  ncp_op
);

    logic sel_cmp;

    always_comb begin
        case (op_type)
            fpu_ncp_pkg::OP_CLASS: ncp_op = fpu_ncp_pkg::CLASS;
            fpu_ncp_pkg::OP_CMP: begin
                case (frm)
                    3'd0:    ncp_op = fpu_ncp_pkg::LE;
                    3'd1:    ncp_op = fpu_ncp_pkg::LT;
                    3'd2:    ncp_op = fpu_ncp_pkg::EQ;
                    // an unused compare modifier degrades to a move.
                    default: ncp_op = fpu_ncp_pkg::MV;
                endcase
            end
            default: begin
                case (frm)
                    3'd0:    ncp_op = fpu_ncp_pkg::SGNJ;
                    3'd1:    ncp_op = fpu_ncp_pkg::SGNJN;
                    3'd2:    ncp_op = fpu_ncp_pkg::SGNJX;
                    3'd3:    ncp_op = fpu_ncp_pkg::MIN;
                    3'd4:    ncp_op = fpu_ncp_pkg::MAX;
                    default: ncp_op = fpu_ncp_pkg::MV;
                endcase
            end
        endcase
    end

    // everything that can raise a flag runs in the compare lane.
    assign sel_cmp = (ncp_op == fpu_ncp_pkg::LE)
                  || (ncp_op == fpu_ncp_pkg::LT)
                  || (ncp_op == fpu_ncp_pkg::EQ)
                  || (ncp_op == fpu_ncp_pkg::MIN)
                  || (ncp_op == fpu_ncp_pkg::MAX);

    assign cmp_valid = valid_in && sel_cmp;
    assign sgn_valid = valid_in && !sel_cmp;
    assign ready_in  = sel_cmp ? cmp_ready : sgn_ready;

endmodule

`default_nettype wire

// ==== src/fpu_shift_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module fpu_shift_reg #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  logic     valid_d,
    input  payload_t data_d,
    output logic     valid_q,
    output payload_t data_q
);

    logic     valid_r [DEPTH];
    payload_t data_r  [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_r[i] <= 1'b0;
            end
        end else if (enable) begin
            valid_r[0] <= valid_d;
            for (int i = 1; i < DEPTH; i++) begin
                valid_r[i] <= valid_r[i-1];
            end
        end
    end

    // payload stages advance in step with the valid bits.
    always_ff @(posedge clk) begin
        if (enable) begin
            data_r[0] <= data_d;
            for (int i = 1; i < DEPTH; i++) begin
                data_r[i] <= data_r[i-1];
            end
        end
    end

    assign valid_q = valid_r[DEPTH-1];
    assign data_q  = data_r[DEPTH-1];

endmodule

`default_nettype wire

// ==== src/fpu_cmp_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fpu_cmp_unit #(
    parameter int NUM_THREADS = 4,
    parameter int TAGW        = 8,
    parameter int LATENCY     = 2
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid,
    input  fpu_ncp_pkg::ncp_op_t                  ncp_op,
    input  logic [TAGW-1:0]                       tag_in,
    input  fpu_ncp_pkg::word_t [NUM_THREADS-1:0]  dataa,
    input  fpu_ncp_pkg::word_t [NUM_THREADS-1:0]  datab,
    output logic                                  in_ready,
    fpu_lane_if.lane                              out,
    output fpu_ncp_pkg::fflags_t [NUM_THREADS-1:0] fflags
);

    typedef struct packed {
        logic [TAGW-1:0]                       tag;
        fpu_ncp_pkg::word_t [NUM_THREADS-1:0]  result;
        fpu_ncp_pkg::fflags_t [NUM_THREADS-1:0] fflags;
    } cmp_payload_t;

    fpu_ncp_pkg::word_t [NUM_THREADS-1:0]   cmp_result;
    fpu_ncp_pkg::fflags_t [NUM_THREADS-1:0] cmp_flags;
    cmp_payload_t                           pipe_d;
    cmp_payload_t                           pipe_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-thread compare datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_thread
        logic                 a_nan, b_nan, a_snan, b_snan, any_snan, any_nan;
        logic                 both_zero, lt_total, lt_ord, eq_ord;
        fpu_ncp_pkg::word_t   res;
        fpu_ncp_pkg::fflags_t flg;

        assign a_nan    = (&dataa[i][30:23]) && (|dataa[i][22:0]);
        assign b_nan    = (&datab[i][30:23]) && (|datab[i][22:0]);
        assign a_snan   = a_nan && !dataa[i][22];
        assign b_snan   = b_nan && !datab[i][22];
        assign any_nan  = a_nan || b_nan;
        assign any_snan = a_snan || b_snan;

        assign both_zero = (dataa[i][30:0] == 31'd0) && (datab[i][30:0] == 31'd0);

        // total order on non-NaN values, where -0 sorts below +0.
        assign lt_total = (dataa[i][31] != datab[i][31]) ? dataa[i][31] :
                          dataa[i][31] ? (dataa[i][30:0] > datab[i][30:0])
                                       : (dataa[i][30:0] < datab[i][30:0]);

        assign lt_ord = lt_total && !both_zero;
        assign eq_ord = both_zero || (dataa[i] == datab[i]);

        always_comb begin
            res    = '0;
            flg    = '0;
            flg.nv = any_snan;
            case (ncp_op)
                fpu_ncp_pkg::LT: begin
                    res[0] = !any_nan && lt_ord;
                    flg.nv = any_nan;
                end
                fpu_ncp_pkg::LE: begin
                    res[0] = !any_nan && (lt_ord || eq_ord);
                    flg.nv = any_nan;
                end
                fpu_ncp_pkg::EQ: res[0] = !any_nan && eq_ord;
                fpu_ncp_pkg::MIN, fpu_ncp_pkg::MAX: begin
                    if (a_nan && b_nan) begin
                        res = fpu_ncp_pkg::CANONICAL_NAN;
                    end else if (a_nan) begin
                        res = datab[i];
                    end else if (b_nan) begin
                        res = dataa[i];
                    end else if (lt_total == (ncp_op == fpu_ncp_pkg::MIN)) begin
                        res = dataa[i];
                    end else begin
                        res = datab[i];
                    end
                end
                default: flg.nv = 1'b0;
            endcase
        end

        assign cmp_result[i] = res;
        assign cmp_flags[i]  = flg;
    end

    // the whole chain stalls together while the last stage waits for a grant.
    assign in_ready = !out.valid || out.ready;

    assign pipe_d.tag    = tag_in;
    assign pipe_d.result = cmp_result;
    assign pipe_d.fflags = cmp_flags;

    fpu_shift_reg #(
        .payload_t (cmp_payload_t),
        .DEPTH     (LATENCY)
    ) u_pipe (
        .clk     (clk),
        .reset   (reset),
        .enable  (in_ready),
        .valid_d (in_valid),
        .data_d  (pipe_d),
        .valid_q (out.valid),
        .data_q  (pipe_q)
    );

    assign out.tag    = pipe_q.tag;
    assign out.result = pipe_q.result;
    assign fflags     = pipe_q.fflags;

endmodule

`default_nettype wire

// ==== src/fpu_sgn_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fpu_sgn_unit #(
    parameter int NUM_THREADS = 4,
    parameter int TAGW        = 8,
    parameter int LATENCY     = 1
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid,
    input  fpu_ncp_pkg::ncp_op_t                  ncp_op,
    input  logic [TAGW-1:0]                       tag_in,
    input  fpu_ncp_pkg::word_t [NUM_THREADS-1:0]  dataa,
    input  fpu_ncp_pkg::word_t [NUM_THREADS-1:0]  datab,
    output logic                                  in_ready,
    fpu_lane_if.lane                              out
);

    typedef struct packed {
        logic [TAGW-1:0]                       tag;
        fpu_ncp_pkg::word_t [NUM_THREADS-1:0]  result;
    } sgn_payload_t;

    fpu_ncp_pkg::word_t [NUM_THREADS-1:0] sgn_result;
    sgn_payload_t                         pipe_d;
    sgn_payload_t                         pipe_q;

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_thread
        logic               exp_ones, exp_zero, man_zero;
        logic [9:0]         cls;
        fpu_ncp_pkg::word_t res;

        assign exp_ones = &dataa[i][30:23];
        assign exp_zero = ~|dataa[i][30:23];
        assign man_zero = ~|dataa[i][22:0];

        // the classify mask is one-hot.
        always_comb begin
            cls = '0;
            if (exp_ones && !man_zero) begin
                cls[8] = !dataa[i][22];
                cls[9] = dataa[i][22];
            end else if (exp_ones) begin
                cls[0] = dataa[i][31];
                cls[7] = !dataa[i][31];
            end else if (exp_zero && man_zero) begin
                cls[3] = dataa[i][31];
                cls[4] = !dataa[i][31];
            end else if (exp_zero) begin
                cls[2] = dataa[i][31];
                cls[5] = !dataa[i][31];
            end else begin
                cls[1] = dataa[i][31];
                cls[6] = !dataa[i][31];
            end
        end

        always_comb begin
            case (ncp_op)
                fpu_ncp_pkg::SGNJ:  res = {datab[i][31], dataa[i][30:0]};
                fpu_ncp_pkg::SGNJN: res = {!datab[i][31], dataa[i][30:0]};
                fpu_ncp_pkg::SGNJX: res = {dataa[i][31] ^ datab[i][31], dataa[i][30:0]};
                fpu_ncp_pkg::CLASS: res = {22'd0, cls};
                default:            res = dataa[i];
            endcase
        end

        assign sgn_result[i] = res;
    end

    assign in_ready = !out.valid || out.ready;

    assign pipe_d.tag    = tag_in;
    assign pipe_d.result = sgn_result;

    fpu_shift_reg #(
        .payload_t (sgn_payload_t),
        .DEPTH     (LATENCY)
    ) u_pipe (
        .clk     (clk),
        .reset   (reset),
        .enable  (in_ready),
        .valid_d (in_valid),
        .data_d  (pipe_d),
        .valid_q (out.valid),
        .data_q  (pipe_q)
    );

    assign out.tag    = pipe_q.tag;
    assign out.result = pipe_q.result;

endmodule

`default_nettype wire

// ==== src/fpu_result_arb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fpu_result_arb #(
    parameter int NUM_THREADS = 4,
    parameter int TAGW        = 8
) (
    fpu_lane_if.arb                                lanes [fpu_ncp_pkg::NUM_LANES],
    input  fpu_ncp_pkg::fflags_t [NUM_THREADS-1:0] cmp_fflags,
    input  logic                                   ready_out,
    output logic                                   valid_out,
    output fpu_ncp_pkg::word_t [NUM_THREADS-1:0]   result,
    output logic [TAGW-1:0]                        tag_out,
    output logic                                   has_fflags,
    output fpu_ncp_pkg::fflags_t [NUM_THREADS-1:0] fflags
);

    localparam int NL = fpu_ncp_pkg::NUM_LANES;

    logic [NL-1:0]                        lane_valid;
    logic [NL-1:0]                        grant;
    logic [TAGW-1:0]                      lane_tag    [NL];
    fpu_ncp_pkg::word_t [NUM_THREADS-1:0] lane_result [NL];
    logic                                 taken;

    for (genvar i = 0; i < NL; i++) begin : g_lane
        assign lane_valid[i]  = lanes[i].valid;
        assign lane_tag[i]    = lanes[i].tag;
        assign lane_result[i] = lanes[i].result;
        assign lanes[i].ready = grant[i] && ready_out;
    end

    // the lowest valid lane always wins the grant.
    always_comb begin
        grant   = '0;
        taken   = 1'b0;
        result  = '0;
        tag_out = '0;
        for (int i = 0; i < NL; i++) begin
            if (lane_valid[i] && !taken) begin
                grant[i] = 1'b1;
                result   = lane_result[i];
                tag_out  = lane_tag[i];
            end
            taken = taken || lane_valid[i];
        end
    end

    assign valid_out  = |lane_valid;
    assign has_fflags = grant[fpu_ncp_pkg::LANE_CMP];
    assign fflags     = has_fflags ? cmp_fflags : '0;

endmodule

`default_nettype wire

// ==== src/fpu_ncp.sv ====
`timescale 1ns/10ps
`default_nettype none

module fpu_ncp #(
    parameter int NUM_THREADS = 4,
    parameter int TAGW        = 8,
    parameter int LATENCY_CMP = 2,
    parameter int LATENCY_SGN = 1
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   valid_in,
    output logic                                   ready_in,
    input  logic [TAGW-1:0]                        tag_in,
    input  fpu_ncp_pkg::fpu_op_t                   op_type,
    input  fpu_ncp_pkg::frm_t                      frm,
    input  fpu_ncp_pkg::word_t [NUM_THREADS-1:0]   dataa,
    input  fpu_ncp_pkg::word_t [NUM_THREADS-1:0]   datab,
    output fpu_ncp_pkg::word_t [NUM_THREADS-1:0]   result,
    output logic                                   has_fflags,
    output fpu_ncp_pkg::fflags_t [NUM_THREADS-1:0] fflags,
    output logic [TAGW-1:0]                        tag_out,
    input  logic                                   ready_out,
    output logic                                   valid_out
);

    logic                                   cmp_valid;
    logic                                   sgn_valid;
    logic                                   cmp_ready;
    logic                                   sgn_ready;
    fpu_ncp_pkg::ncp_op_t                   ncp_op;
    fpu_ncp_pkg::fflags_t [NUM_THREADS-1:0] cmp_fflags;

    fpu_lane_if #(
        .NUM_THREADS (NUM_THREADS),
        .TAGW        (TAGW)
    ) lane_bus [fpu_ncp_pkg::NUM_LANES] ();

    fpu_ncp_decode u_decode (
        .valid_in  (valid_in),
        .op_type   (op_type),
        .frm       (frm),
        .cmp_ready (cmp_ready),
        .sgn_ready (sgn_ready),
        .cmp_valid (cmp_valid),
        .sgn_valid (sgn_valid),
        .ready_in  (ready_in),
        .ncp_op    (ncp_op)
    );

    fpu_cmp_unit #(
        .NUM_THREADS (NUM_THREADS),
        .TAGW        (TAGW),
        .LATENCY     (LATENCY_CMP)
    ) u_cmp (
        .clk      (clk),
        .reset    (reset),
        .in_valid (cmp_valid),
        .ncp_op   (ncp_op),
        .tag_in   (tag_in),
        .dataa    (dataa),
        .datab    (datab),
        .in_ready (cmp_ready),
        .out      (lane_bus[fpu_ncp_pkg::LANE_CMP]),
        .fflags   (cmp_fflags)
    );

    fpu_sgn_unit #(
        .NUM_THREADS (NUM_THREADS),
        .TAGW        (TAGW),
        .LATENCY     (LATENCY_SGN)
    ) u_sgn (
        .clk      (clk),
        .reset    (reset),
        .in_valid (sgn_valid),
        .ncp_op   (ncp_op),
        .tag_in   (tag_in),
        .dataa    (dataa),
        .datab    (datab),
        .in_ready (sgn_ready),
        .out      (lane_bus[fpu_ncp_pkg::LANE_SGN])
    );

    fpu_result_arb #(
        .NUM_THREADS (NUM_THREADS),
        .TAGW        (TAGW)
    ) u_arb (
        .lanes      (lane_bus),
        .cmp_fflags (cmp_fflags),
        .ready_out  (ready_out),
        .valid_out  (valid_out),
        .result     (result),
        .tag_out    (tag_out),
        .has_fflags (has_fflags),
        .fflags     (fflags)
    );

endmodule

`default_nettype wire

// ==== bench/fpu_ncp_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module fpu_ncp_properties #(
    parameter int NUM_THREADS = 4,
    parameter int TAGW        = 8
) (
    input logic                                   clk,
    input logic                                   reset,
    input logic                                   valid_out,
    input logic                                   ready_out,
    input logic                                   has_fflags,
    input logic [TAGW-1:0]                        tag_out,
    input fpu_ncp_pkg::word_t [NUM_THREADS-1:0]   result,
    input fpu_ncp_pkg::fflags_t [NUM_THREADS-1:0] fflags
);

    a_idle_after_reset: assert property (
        @(posedge clk) reset |=> !valid_out
    ) else $error("valid_out is high in the cycle after reset");

    // the compare lane has top priority, so a stalled compare result cannot be overtaken.
    a_stable_under_stall: assert property (
        @(posedge clk) disable iff (reset)
        valid_out && !ready_out && has_fflags |=>
            valid_out && has_fflags && $stable(result) && $stable(tag_out) && $stable(fflags)
    ) else $error("output changed while held by back-pressure");

    a_flags_zero: assert property (
        @(posedge clk) disable iff (reset)
        !has_fflags |-> (fflags == '0)
    ) else $error("fflags are nonzero while has_fflags is low");

endmodule

bind fpu_ncp fpu_ncp_properties #(
    .NUM_THREADS (NUM_THREADS),
    .TAGW        (TAGW)
) u_props (
    .clk        (clk),
    .reset      (reset),
    .valid_out  (valid_out),
    .ready_out  (ready_out),
    .has_fflags (has_fflags),
    .tag_out    (tag_out),
    .result     (result),
    .fflags     (fflags)
);

`default_nettype wire

// ==== bench/fpu_ncp_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fpu_ncp_tb;

    localparam int NUM_THREADS    = 4;
    localparam int TAGW           = 8;
    localparam int NUM_TAGS       = 1 << TAGW;
    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 20;

    typedef struct packed {
        fpu_ncp_pkg::word_t   res;
        fpu_ncp_pkg::fflags_t flg;
        logic                 has;
    } expect_t;

    logic                                   clk = 1'b0;
    logic                                   reset;
    logic                                   valid_in;
    logic                                   ready_in;
    logic [TAGW-1:0]                        tag_in;
    fpu_ncp_pkg::fpu_op_t                   op_type;
    fpu_ncp_pkg::frm_t                      frm;
    fpu_ncp_pkg::word_t [NUM_THREADS-1:0]   dataa;
    fpu_ncp_pkg::word_t [NUM_THREADS-1:0]   datab;
    fpu_ncp_pkg::word_t [NUM_THREADS-1:0]   result;
    logic                                   has_fflags;
    fpu_ncp_pkg::fflags_t [NUM_THREADS-1:0] fflags;
    logic [TAGW-1:0]                        tag_out;
    logic                                   ready_out;
    logic                                   valid_out;

    logic [31:0]          rng_state = 32'h6a4;
    int                   issued    = 0;
    int                   accepted  = 0;
    int                   retired   = 0;
    int                   cycles    = 0;
    int                   accept_cnt [NUM_TAGS];
    int                   retire_cnt [NUM_TAGS];
    fpu_ncp_pkg::word_t   cur_result [NUM_THREADS];
    fpu_ncp_pkg::fflags_t cur_flags  [NUM_THREADS];
    logic                 cur_has;
    fpu_ncp_pkg::word_t   exp_result [NUM_TAGS][NUM_THREADS];
    fpu_ncp_pkg::fflags_t exp_flags  [NUM_TAGS][NUM_THREADS];
    logic                 exp_has    [NUM_TAGS];

    always #5 clk = ~clk;

    fpu_ncp #(
        .NUM_THREADS (NUM_THREADS),
        .TAGW        (TAGW)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (valid_in),
        .ready_in   (ready_in),
        .tag_in     (tag_in),
        .op_type    (op_type),
        .frm        (frm),
        .dataa      (dataa),
        .datab      (datab),
        .result     (result),
        .has_fflags (has_fflags),
        .fflags     (fflags),
        .tag_out    (tag_out),
        .ready_out  (ready_out),
        .valid_out  (valid_out)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random numbers and operands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic hit_odds(input int num, input int den);
        logic [31:0] r;
        r = rand_word();
        return (r % den) < num;
    endfunction

    // special values are favoured so that every compare and class corner shows up.
    function automatic fpu_ncp_pkg::word_t pick_operand();
        logic [31:0] r;
        logic [31:0] m;
        r = rand_word();
        m = rand_word();
        case (r[3:0])
            4'd0:    return {r[31], 31'd0};
            4'd1:    return {r[31], 8'hff, 23'd0};
            4'd2:    return {r[31], 8'hff, 1'b1, m[21:0]};
            4'd3:    return {r[31], 8'hff, 1'b0, m[21:1], 1'b1};
            4'd4:    return {r[31], 8'h00, m[22:1], 1'b1};
            4'd5,
            4'd6,
            4'd7:    return {r[31], 6'b011111, r[5:4], m[22:20], 20'd0};
            default: return m;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int class_index(input fpu_ncp_pkg::word_t x);
        if (x[30:23] == 8'hff) begin
            if (x[22:0] == 23'd0) return x[31] ? 0 : 7;
            return x[22] ? 9 : 8;
        end
        if (x[30:23] == 8'h00) begin
            if (x[22:0] == 23'd0) return x[31] ? 3 : 4;
            return x[31] ? 2 : 5;
        end
        return x[31] ? 1 : 6;
    endfunction

    function automatic expect_t ref_ncp(input fpu_ncp_pkg::fpu_op_t op,
                                        input fpu_ncp_pkg::frm_t rm,
                                        input fpu_ncp_pkg::word_t a,
                                        input fpu_ncp_pkg::word_t b);
        expect_t              e;
        fpu_ncp_pkg::ncp_op_t sub;
        logic                 a_nan, b_nan, nan, snan, zeros, eq, lt;
        logic [31:0]          ka, kb;
        a_nan = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
        b_nan = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
        nan   = a_nan || b_nan;
        snan  = (a_nan && !a[22]) || (b_nan && !b[22]);
        zeros = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
        // an unsigned key that orders floats, with -0 just below +0.
        ka    = a[31] ? ~a : (a | 32'h8000_0000);
        kb    = b[31] ? ~b : (b | 32'h8000_0000);
        eq    = zeros || (a == b);
        lt    = !zeros && (ka < kb);
        if (op == fpu_ncp_pkg::OP_CLASS) begin
            sub = fpu_ncp_pkg::CLASS;
        end else if (op == fpu_ncp_pkg::OP_CMP) begin
            sub = (rm == 3'd0) ? fpu_ncp_pkg::LE : (rm == 3'd1) ? fpu_ncp_pkg::LT :
                  (rm == 3'd2) ? fpu_ncp_pkg::EQ : fpu_ncp_pkg::MV;
        end else begin
            case (rm)
                3'd0:    sub = fpu_ncp_pkg::SGNJ;
                3'd1:    sub = fpu_ncp_pkg::SGNJN;
                3'd2:    sub = fpu_ncp_pkg::SGNJX;
                3'd3:    sub = fpu_ncp_pkg::MIN;
                3'd4:    sub = fpu_ncp_pkg::MAX;
                default: sub = fpu_ncp_pkg::MV;
            endcase
        end
        e = '0;
        case (sub)
            fpu_ncp_pkg::LT,
            fpu_ncp_pkg::LE: begin
                e.has    = 1'b1;
                e.flg.nv = nan;
                e.res    = {31'd0, !nan && (lt || (sub == fpu_ncp_pkg::LE && eq))};
            end
            fpu_ncp_pkg::EQ: begin
                e.has    = 1'b1;
                e.flg.nv = snan;
                e.res    = {31'd0, !nan && eq};
            end
            fpu_ncp_pkg::MIN,
            fpu_ncp_pkg::MAX: begin
                e.has    = 1'b1;
                e.flg.nv = snan;
                if (a_nan && b_nan) e.res = fpu_ncp_pkg::CANONICAL_NAN;
                else if (a_nan) e.res = b;
                else if (b_nan) e.res = a;
                else if (sub == fpu_ncp_pkg::MIN) e.res = (ka < kb) ? a : b;
                else e.res = (ka > kb) ? a : b;
            end
            fpu_ncp_pkg::SGNJ:  e.res = {b[31], a[30:0]};
            fpu_ncp_pkg::SGNJN: e.res = {~b[31], a[30:0]};
            fpu_ncp_pkg::SGNJX: e.res = {a[31] ^ b[31], a[30:0]};
            fpu_ncp_pkg::CLASS: e.res = 32'd1 << class_index(a);
            default:            e.res = a;
        endcase
        return e;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_word(input string name, input fpu_ncp_pkg::word_t exp,
                              input fpu_ncp_pkg::word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "result word mismatch");
        end
    endtask

    task automatic check_fflags(input string name, input fpu_ncp_pkg::fflags_t exp,
                                input fpu_ncp_pkg::fflags_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "flag valid mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic issue_op();
        fpu_ncp_pkg::fpu_op_t                 op;
        fpu_ncp_pkg::frm_t                    rm;
        fpu_ncp_pkg::word_t [NUM_THREADS-1:0] a;
        fpu_ncp_pkg::word_t [NUM_THREADS-1:0] b;
        logic [31:0]                          r;
        logic [31:0]                          m;
        expect_t                              e;
        r = rand_word();
        case (r[1:0])
            2'd0:    op = fpu_ncp_pkg::OP_CLASS;
            2'd1:    op = fpu_ncp_pkg::OP_CMP;
            2'd2:    op = fpu_ncp_pkg::OP_MISC;
            default: op = fpu_ncp_pkg::fpu_op_t'(4'(r[4:2]) + 4'd3);
        endcase
        rm = (op == fpu_ncp_pkg::OP_CMP) ? {1'b0, r[9:8]} : r[10:8];
        for (int i = 0; i < NUM_THREADS; i++) begin
            a[i] = pick_operand();
            m    = rand_word();
            if (m[2:0] == 3'd0) b[i] = a[i];
            else if (m[2:0] == 3'd1) b[i] = a[i] ^ 32'h8000_0000;
            else b[i] = pick_operand();
            e = ref_ncp(op, rm, a[i], b[i]);
            cur_result[i] = e.res;
            cur_flags[i]  = e.flg;
            cur_has       = e.has;
        end
        valid_in <= 1'b1;
        tag_in   <= TAGW'(issued);
        op_type  <= op;
        frm      <= rm;
        dataa    <= a;
        datab    <= b;
        issued   = issued + 1;
    endtask

    task automatic record_accept(input logic [TAGW-1:0] tag);
        if (accept_cnt[tag] != retire_cnt[tag]) begin
            $display("tag %h accepted again before its earlier result left", tag);
            $display("Test FAILED");
            $fatal(1, "tag reuse");
        end else begin
            for (int i = 0; i < NUM_THREADS; i++) begin
                exp_result[tag][i] = cur_result[i];
                exp_flags[tag][i]  = cur_flags[i];
            end
            exp_has[tag]    = cur_has;
            accept_cnt[tag] = accept_cnt[tag] + 1;
            accepted        = accepted + 1;
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (valid_in && ready_in) begin
                record_accept(tag_in);
            end
            if (!valid_in || ready_in) begin
                if (issued < NUM_OPS && hit_odds(7, 8)) begin
                    issue_op();
                end else begin
                    valid_in <= 1'b0;
                end
            end
            ready_out <= hit_odds(3, 4);
        end
    end

    // the scoreboard is checked at every output transfer.
    always @(posedge clk) begin
        if (!reset && valid_out && ready_out) begin
            if (accept_cnt[tag_out] == retire_cnt[tag_out]) begin
                $display("output with tag %h arrived without an outstanding operation", tag_out);
                $display("Test FAILED");
                $fatal(1, "unexpected output");
            end else begin
                check_bit($sformatf("has_fflags tag %h", tag_out), exp_has[tag_out], has_fflags);
                for (int i = 0; i < NUM_THREADS; i++) begin
                    check_word($sformatf("result[%0d] tag %h", i, tag_out),
                               exp_result[tag_out][i], result[i]);
                    check_fflags($sformatf("fflags[%0d] tag %h", i, tag_out),
                                 exp_flags[tag_out][i], fflags[i]);
                end
                retire_cnt[tag_out] = retire_cnt[tag_out] + 1;
                retired = retired + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d operations retired",
                     cycles, retired, NUM_OPS);
            $display("Test FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    initial begin
        reset     <= 1'b1;
        valid_in  <= 1'b0;
        tag_in    <= '0;
        op_type   <= fpu_ncp_pkg::OP_CLASS;
        frm       <= '0;
        dataa     <= '0;
        datab     <= '0;
        ready_out <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (retired < NUM_OPS) @(posedge clk);
        // a few idle cycles catch any stray output after the last result.
        repeat (10) @(posedge clk);
        if (accepted == NUM_OPS && retired == accepted) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("run ended with %0d accepted and %0d retired operations",
                     accepted, retired);
            $display("Test FAILED");
            $fatal(1, "operation count mismatch");
        end
    end

endmodule

`default_nettype wire

// ==== fpu_ncp.f ====
src/fpu_ncp_pkg.sv
src/fpu_lane_if.sv
src/fpu_ncp_decode.sv
src/fpu_shift_reg.sv
src/fpu_cmp_unit.sv
src/fpu_sgn_unit.sv
src/fpu_result_arb.sv
src/fpu_ncp.sv
bench/fpu_ncp_properties.sv
bench/fpu_ncp_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fpu_ncp_tb
FILELIST  = fpu_ncp.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# the run passes only when the pass line shows up in the simulator output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
